// ==== design/wbuf_config.svh ====
`ifndef WBUF_CONFIG_SVH
`define WBUF_CONFIG_SVH

// ==========================================================================
// Weight buffer sizing
// ==========================================================================

// One weight word carries four signed 8-bit weights.
`define WBUF_DATA_W 32

// Words held by the single-port weight SRAM.
`define WBUF_DEPTH 1024

`define WBUF_ADDR_W 10  // Must cover WBUF_DEPTH.

// Width of the engine's run-length count.
`define WBUF_RUN_W 8

`endif

// ==== design/wbuf_pkg.sv ====
`include "wbuf_config.svh"

package wbuf_pkg;

  // Arbiter states of the weight buffer.
  typedef enum logic [2:0] {
    IDLE    = 3'h0,
    ENG_RW  = 3'h1,  // Engine owns the SRAM.
    HOST_AR = 3'h2,  // Host read address phase.
    HOST_R  = 3'h3,  // Host read data phase.
    HOST_W  = 3'h4   // Host write session.
  } wbuf_state_t;

  typedef logic signed [7:0] lane_t;

  // A weight word is moved as a raw word and consumed as four signed lanes.
  typedef union packed {
    logic [`WBUF_DATA_W-1:0] raw;
    lane_t [3:0]             lane;
  } weight_word_u;

  // Dot-product accumulator.
  typedef logic signed [31:0] acc_t;

endpackage

// ==== design/sram_bus_if.sv ====
`timescale 1ns/100ps
`include "wbuf_config.svh"

interface sram_bus_if;

  logic                    cs;
  logic                    oe;
  logic [`WBUF_ADDR_W-1:0] addr;
  logic                    w_req;   // Active high write request.
  logic [`WBUF_DATA_W-1:0] w_data;
  logic [`WBUF_DATA_W-1:0] r_data;

  // Agent side of the bus.
  modport master (
    output cs, oe, addr, w_req, w_data,
    input  r_data
  );

  modport memory (
    input  cs, oe, addr, w_req, w_data,
    output r_data
  );

endinterface

// ==== design/weight_loader.sv ====
`timescale 1ns/100ps
`include "wbuf_config.svh"

module weight_loader (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    sess_i,
  input  logic                    wr_i,
  input  logic                    rd_i,
  input  logic [`WBUF_ADDR_W-1:0] base_i,
  input  logic [`WBUF_ADDR_W-1:0] addr_i,
  input  logic [`WBUF_DATA_W-1:0] wdata_i,
  output logic                    ready_o,
  output logic                    rvalid_o,
  output logic [`WBUF_DATA_W-1:0] rdata_o,
  input  logic                    host_gnt_i,
  output logic                    host_req_o,
  sram_bus_if.master              host_bus
);

  logic                    sess_q;
  logic                    rd_s1;     // Read address phase.
  logic                    rd_s2;     // Read data phase.
  logic                    wr_fire;
  logic                    rd_fire;
  logic [`WBUF_ADDR_W-1:0] wr_addr;
  logic [`WBUF_ADDR_W-1:0] wr_cur;
  logic [`WBUF_ADDR_W-1:0] rd_addr_q;

  // A read in flight blocks new strobes until its data returns.
  assign ready_o    = sess_i && host_gnt_i && !rd_s1 && !rd_s2;
  assign wr_fire    = wr_i && ready_o;
  assign rd_fire    = rd_i && ready_o && !wr_i;  // Write wins a tie.
  assign host_req_o = sess_i || rd_s1 || rd_s2;

  // The first strobe of a session writes at base_i.
  assign wr_cur = sess_q ? wr_addr : base_i;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sess_q  <= 1'b0;
      wr_addr <= '0;
      rd_s1   <= 1'b0;
      rd_s2   <= 1'b0;
    end else begin
      sess_q  <= sess_i;
      wr_addr <= wr_fire ? wr_cur + 1'b1 : wr_cur;
      rd_s1   <= rd_fire;
      rd_s2   <= rd_s1;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) rd_addr_q <= addr_i;
  end

  // ==========================================================================
  // Memory port
  // ==========================================================================

  assign host_bus.cs     = wr_fire || rd_s1;
  assign host_bus.oe     = rd_s1;
  assign host_bus.addr   = rd_s1 ? rd_addr_q : wr_cur;
  assign host_bus.w_req  = wr_fire;
  assign host_bus.w_data = wdata_i;

  assign rvalid_o = rd_s2;
  assign rdata_o  = rd_s2 ? host_bus.r_data : '0;  // SRAM output is registered.

endmodule

// ==== design/weight_sram.sv ====
`timescale 1ns/100ps
`include "wbuf_config.svh"

module weight_sram (
  input logic         clk,
  sram_bus_if.memory  mem
);

  logic [`WBUF_DATA_W-1:0] ram [`WBUF_DEPTH];
  logic [`WBUF_DATA_W-1:0] rd_q;

  // ==========================================================================
  // Single port, one access per cycle
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (mem.cs && mem.w_req) begin
      ram[mem.addr] <= mem.w_data;
    end
  end

  // Read data appears one cycle after the address.
  always_ff @(posedge clk) begin
    if (mem.cs && mem.oe) begin
      rd_q <= ram[mem.addr];
    end
  end

  assign mem.r_data = rd_q;  // Holds until the next read.

endmodule

// ==== design/weight_buffer.sv ====
`timescale 1ns/100ps

module weight_buffer (
  input  logic        clk,
  input  logic        rst,
  input  logic        host_req_i,
  input  logic        host_rd_i,
  input  logic        eng_req_i,
  output logic        host_gnt_o,
  output logic        eng_gnt_o,
  sram_bus_if.memory  host_bus,
  sram_bus_if.memory  eng_bus,
  sram_bus_if.master  mem_bus
);

  import wbuf_pkg::*;

  wbuf_state_t state_q;
  wbuf_state_t state_d;
  logic        host_rd_phase;

  // ==========================================================================
  // Arbiter FSM
  // ==========================================================================

  always_ff @(posedge clk or posedge rst) begin
    if (rst) state_q <= IDLE;
    else     state_q <= state_d;
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        // The engine has priority over the host.
        if (eng_req_i)                             state_d = ENG_RW;
        else if (host_req_i && host_bus.w_req)     state_d = HOST_W;
        else if (host_req_i && host_rd_i)          state_d = HOST_AR;
      end
      HOST_AR: state_d = HOST_R;
      HOST_R:  state_d = IDLE;
      HOST_W:  if (!host_req_i) state_d = IDLE;
      ENG_RW:  if (!eng_req_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  assign host_rd_phase = (state_q == HOST_AR) || (state_q == HOST_R);

  // In IDLE the host port is open so that the first write of a session lands
  // in the same cycle as its strobe.
  assign eng_gnt_o  = (state_q == ENG_RW);
  assign host_gnt_o = host_rd_phase || (state_q == HOST_W) ||
                      ((state_q == IDLE) && host_req_i && !eng_req_i);

  // ==========================================================================
  // Port mux
  // ==========================================================================

  always_comb begin
    mem_bus.cs      = 1'b0;
    mem_bus.oe      = 1'b0;
    mem_bus.addr    = '0;
    mem_bus.w_req   = 1'b0;
    mem_bus.w_data  = '0;
    host_bus.r_data = '0;
    eng_bus.r_data  = '0;
    if (eng_gnt_o) begin
      mem_bus.cs     = eng_bus.cs;
      mem_bus.oe     = eng_bus.oe;
      mem_bus.addr   = eng_bus.addr;
      mem_bus.w_req  = eng_bus.w_req;
      mem_bus.w_data = eng_bus.w_data;
      eng_bus.r_data = mem_bus.r_data;
    end else if (host_gnt_o) begin
      mem_bus.cs      = host_bus.cs;
      mem_bus.oe      = host_bus.oe;
      mem_bus.addr    = host_bus.addr;
      mem_bus.w_req   = host_bus.w_req && !host_rd_phase;  // No writes while reading.
      mem_bus.w_data  = host_bus.w_data;
      host_bus.r_data = mem_bus.r_data;
    end
  end

endmodule

// ==== design/dot_engine.sv ====
`timescale 1ns/100ps
`include "wbuf_config.svh"

module dot_engine (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    start_i,
  input  logic [`WBUF_ADDR_W-1:0] base_i,
  input  logic [`WBUF_RUN_W-1:0]  count_i,
  input  wbuf_pkg::weight_word_u  act_i,
  input  logic                    eng_gnt_i,
  output logic                    eng_req_o,
  output logic                    done_o,
  output wbuf_pkg::acc_t          result_o,
  sram_bus_if.master              eng_bus
);

  import wbuf_pkg::*;

  logic                    req_q;
  logic                    rd_pend;   // Read data returns this cycle.
  logic                    done_q;
  logic                    busy;
  logic                    issue;
  logic [`WBUF_ADDR_W-1:0] iss_addr;
  logic [`WBUF_RUN_W-1:0]  iss_left;
  logic [`WBUF_RUN_W-1:0]  ret_left;
  weight_word_u            act_q;
  weight_word_u            rword;
  acc_t                    acc_q;
  acc_t                    dot_sum;

  assign busy  = req_q || rd_pend;
  assign issue = req_q && eng_gnt_i;
  assign rword = eng_bus.r_data;

  // Four signed lane products, widened to the accumulator.
  always_comb begin
    dot_sum = '0;
    for (int i = 0; i < $size(rword.lane); i++) begin
      dot_sum = dot_sum + rword.lane[i] * act_q.lane[i];
    end
  end

  // ==========================================================================
  // Run control
  // ==========================================================================

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      req_q    <= 1'b0;
      rd_pend  <= 1'b0;
      done_q   <= 1'b0;
      iss_left <= '0;
      ret_left <= '0;
      acc_q    <= '0;
    end else begin
      rd_pend <= issue;
      done_q  <= 1'b0;
      if (start_i && !busy) begin
        req_q    <= 1'b1;
        iss_left <= count_i;
        ret_left <= count_i;
        acc_q    <= '0;
      end
      if (issue) begin
        iss_left <= iss_left - 1'b1;
        if (iss_left == 1) req_q <= 1'b0;  // Release after the last read.
      end
      if (rd_pend) begin
        acc_q    <= acc_q + dot_sum;
        ret_left <= ret_left - 1'b1;
        done_q   <= (ret_left == 1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_i && !busy) begin
      iss_addr <= base_i;
      act_q    <= act_i;
    end else if (issue) begin
      iss_addr <= iss_addr + 1'b1;
    end
  end

  // The engine only reads the buffer.
  assign eng_bus.cs     = issue;
  assign eng_bus.oe     = issue;
  assign eng_bus.addr   = iss_addr;
  assign eng_bus.w_req  = 1'b0;
  assign eng_bus.w_data = '0;

  assign eng_req_o = req_q;
  assign done_o    = done_q;
  assign result_o  = acc_q;

endmodule

// ==== design/weight_subsys_top.sv ====
`timescale 1ns/100ps
`include "wbuf_config.svh"

module weight_subsys_top (
  input  logic                    clk,
  input  logic                    rst,
  // Host port.
  input  logic                    sess_i,
  input  logic                    wr_i,
  input  logic                    rd_i,
  input  logic [`WBUF_ADDR_W-1:0] base_i,
  input  logic [`WBUF_ADDR_W-1:0] addr_i,
  input  logic [`WBUF_DATA_W-1:0] wdata_i,
  output logic                    ready_o,
  output logic                    rvalid_o,
  output logic [`WBUF_DATA_W-1:0] rdata_o,
  // Engine port.
  input  logic                    start_i,
  input  logic [`WBUF_ADDR_W-1:0] eng_base_i,
  input  logic [`WBUF_RUN_W-1:0]  count_i,
  input  wbuf_pkg::weight_word_u  act_i,
  output logic                    done_o,
  output wbuf_pkg::acc_t          result_o
);

  logic host_req;
  logic eng_req;
  logic host_gnt;
  logic eng_gnt;

  sram_bus_if host_bus ();
  sram_bus_if eng_bus ();
  sram_bus_if mem_bus ();

  weight_loader u_loader (
    .clk(clk), .rst(rst), .sess_i(sess_i), .wr_i(wr_i), .rd_i(rd_i),
    .base_i(base_i), .addr_i(addr_i), .wdata_i(wdata_i),
    .ready_o(ready_o), .rvalid_o(rvalid_o), .rdata_o(rdata_o),
    .host_gnt_i(host_gnt), .host_req_o(host_req), .host_bus(host_bus)
  );

  weight_buffer u_buffer (
    .clk(clk), .rst(rst), .host_req_i(host_req), .host_rd_i(rd_i),
    .eng_req_i(eng_req), .host_gnt_o(host_gnt), .eng_gnt_o(eng_gnt),
    .host_bus(host_bus), .eng_bus(eng_bus), .mem_bus(mem_bus)
  );

  weight_sram u_sram (
    .clk(clk),
    .mem(mem_bus)
  );

  dot_engine u_engine (
    .clk(clk), .rst(rst), .start_i(start_i), .base_i(eng_base_i),
    .count_i(count_i), .act_i(act_i), .eng_gnt_i(eng_gnt),
    .eng_req_o(eng_req), .done_o(done_o), .result_o(result_o), .eng_bus(eng_bus)
  );

endmodule

// ==== testbench/weight_subsys_sva.sv ====
`timescale 1ns/100ps

module weight_buffer_sva (
  input logic                  clk,
  input logic                  rst,
  input wbuf_pkg::wbuf_state_t state_i,
  input logic                  host_gnt_i,
  input logic                  eng_gnt_i,
  input logic                  eng_req_i,
  input logic                  host_w_req_i
);

  import wbuf_pkg::*;

  int fail_count = 0;

  // Only one agent owns the SRAM at a time.
  grant_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(host_gnt_i && eng_gnt_i))
    else begin
      fail_count++;
      $error("Host and engine granted in the same cycle.");
    end

  // The loader holds off its writes while one of its reads is in flight.
  no_write_in_read: assert property (@(posedge clk) disable iff (rst)
    (state_i inside {HOST_AR, HOST_R}) |-> !host_w_req_i)
    else begin
      fail_count++;
      $error("Host write request during a host read.");
    end

  // The engine keeps the buffer for as long as it asks for it.
  eng_hold: assert property (@(posedge clk) disable iff (rst)
    (state_i == ENG_RW && eng_req_i) |=> (state_i == ENG_RW))
    else begin
      fail_count++;
      $error("Arbiter left ENG_RW while eng_req was high.");
    end

endmodule

bind weight_buffer weight_buffer_sva u_sva (
  .clk(clk), .rst(rst), .state_i(state_q),
  .host_gnt_i(host_gnt_o), .eng_gnt_i(eng_gnt_o), .eng_req_i(eng_req_i),
  .host_w_req_i(host_bus.w_req)
);

// ==== testbench/weight_subsys_tb.sv ====
`timescale 1ns/100ps
`include "wbuf_config.svh"

module weight_subsys_tb;

  import wbuf_pkg::*;

  typedef enum {OP_WRITE, OP_WRITE_NEG, OP_READ, OP_RUN, OP_SESS_RUN, OP_BLOCKED} op_e;

  typedef struct {
    string                   name;
    op_e                     op;
    logic [`WBUF_ADDR_W-1:0] base;
    int                      count;
    logic [`WBUF_DATA_W-1:0] act;
  } row_t;

  localparam int NUM_ROWS = 10;

  logic                    clk;
  logic                    rst;
  logic                    sess_i;
  logic                    wr_i;
  logic                    rd_i;
  logic [`WBUF_ADDR_W-1:0] base_i;
  logic [`WBUF_ADDR_W-1:0] addr_i;
  logic [`WBUF_DATA_W-1:0] wdata_i;
  logic                    ready_o;
  logic                    rvalid_o;
  logic [`WBUF_DATA_W-1:0] rdata_o;
  logic                    start_i;
  logic [`WBUF_ADDR_W-1:0] eng_base_i;
  logic [`WBUF_RUN_W-1:0]  count_i;
  weight_word_u            act_i;
  logic                    done_o;
  acc_t                    result_o;

  logic [`WBUF_DATA_W-1:0] model [`WBUF_DEPTH];  // Expected SRAM contents.
  logic [`WBUF_ADDR_W-1:0] wr_ptr;
  row_t                    rows [NUM_ROWS];
  int                      err_word = 0;
  int                      err_acc = 0;
  int                      err_proto = 0;
  int                      cycles = 0;
  int                      cycle_limit;

  weight_subsys_top DUT (
    .clk(clk), .rst(rst), .sess_i(sess_i), .wr_i(wr_i), .rd_i(rd_i),
    .base_i(base_i), .addr_i(addr_i), .wdata_i(wdata_i),
    .ready_o(ready_o), .rvalid_o(rvalid_o), .rdata_o(rdata_o),
    .start_i(start_i), .eng_base_i(eng_base_i), .count_i(count_i), .act_i(act_i),
    .done_o(done_o), .result_o(result_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Run stopped after %0d cycles, the DUT never answered.", cycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // ==========================================================================
  // Checks and reference model
  // ==========================================================================

  task automatic check_word(input string tag, input logic [`WBUF_DATA_W-1:0] exp,
                            input logic [`WBUF_DATA_W-1:0] got);
    if (got !== exp) begin
      err_word++;
      $display("ERR %s: expected %h, actual %h", tag, exp, got);
    end
  endtask

  task automatic check_acc(input string tag, input acc_t exp, input acc_t got);
    if (got !== exp) begin
      err_acc++;
      $display("ERR %s: expected %0d, actual %0d", tag, exp, got);
    end
  endtask

  // Sum over the run of the four signed lane products of each word.
  function automatic acc_t dot_model(input logic [`WBUF_ADDR_W-1:0] base, input int count,
                                     input weight_word_u act);
    weight_word_u            w;
    logic [`WBUF_ADDR_W-1:0] a;
    acc_t                    sum;
    sum = 0;
    for (int k = 0; k < count; k++) begin
      a     = base + k;
      w.raw = model[a];
      for (int l = 0; l < 4; l++) sum += int'(w.lane[l]) * int'(act.lane[l]);
    end
    return sum;
  endfunction

  // ==========================================================================
  // Host and engine drivers
  // ==========================================================================

  task next_cycle();
    @(posedge clk);
    #5;
  endtask

  task wait_ready();
    #1;
    while (ready_o !== 1'b1) next_cycle();
  endtask

  task automatic burst_write(input logic [`WBUF_ADDR_W-1:0] base, input int count,
                             input bit negative, input bit close);
    logic [`WBUF_DATA_W-1:0] data;
    sess_i = 1'b1;
    base_i = base;
    wr_ptr = base;
    for (int i = 0; i < count; i++) begin
      data = negative ? ($urandom() | 32'h8080_8080) : $urandom();
      wait_ready();
      wr_i    = 1'b1;
      wdata_i = data;
      model[wr_ptr] = data;
      wr_ptr++;
      next_cycle();
      wr_i = 1'b0;
    end
    if (close) begin
      sess_i = 1'b0;
      repeat (2) next_cycle();
    end
  endtask

  task automatic host_read(input string tag, input logic [`WBUF_ADDR_W-1:0] addr);
    logic [`WBUF_DATA_W-1:0] got;
    addr_i = addr;
    wait_ready();
    rd_i = 1'b1;
    next_cycle();
    rd_i = 1'b0;
    if (rvalid_o !== 1'b0) begin
      err_proto++;
      $display("rvalid_o came one cycle after rd_i in %s.", tag);
    end
    next_cycle();
    got = rdata_o;
    if (rvalid_o !== 1'b1) begin
      err_proto++;
      $display("rvalid_o did not pulse two cycles after rd_i in %s.", tag);
    end
    check_word(tag, model[addr], got);
    next_cycle();
    if (rvalid_o !== 1'b0) begin
      err_proto++;
      $display("rvalid_o stayed high for more than one cycle in %s.", tag);
    end
  endtask

  task automatic read_words(input string tag, input logic [`WBUF_ADDR_W-1:0] base,
                            input int count);
    sess_i = 1'b1;
    for (int i = 0; i < count; i++) host_read($sformatf("%s[%0d]", tag, i), base + i);
    sess_i = 1'b0;
    repeat (2) next_cycle();
  endtask

  task automatic start_engine(input row_t row);
    eng_base_i = row.base;
    count_i    = row.count;
    act_i.raw  = row.act;
    start_i    = 1'b1;
    next_cycle();
    start_i = 1'b0;
  endtask

  task automatic finish_engine(input string tag, input acc_t exp);
    while (done_o !== 1'b1) next_cycle();
    check_acc(tag, exp, result_o);
    next_cycle();
    if (done_o !== 1'b0) begin
      err_proto++;
      $display("done_o stayed high for more than one cycle in %s.", tag);
    end
  endtask

  task automatic apply_row(input row_t row);
    acc_t exp;
    case (row.op)
      OP_WRITE:     burst_write(row.base, row.count, 1'b0, 1'b1);
      OP_WRITE_NEG: burst_write(row.base, row.count, 1'b1, 1'b1);
      OP_READ:      read_words(row.name, row.base, row.count);
      OP_RUN: begin
        exp = dot_model(row.base, row.count, row.act);
        start_engine(row);
        finish_engine(row.name, exp);
      end
      OP_SESS_RUN: begin
        burst_write(row.base, row.count, 1'b0, 1'b0);  // Session stays open.
        exp = dot_model(row.base, row.count, row.act);
        start_engine(row);
        // An engine that was not held off would finish well inside this window.
        repeat (row.count + 8) begin
          next_cycle();
          if (done_o !== 1'b0) begin
            err_proto++;
            $display("Engine finished while the host session was open in %s.", row.name);
          end
        end
        sess_i = 1'b0;
        finish_engine(row.name, exp);
        next_cycle();
      end
      OP_BLOCKED: begin
        exp = dot_model(row.base, row.count, row.act);
        start_engine(row);
        repeat (2) next_cycle();
        sess_i = 1'b1;
        base_i = row.base;
        for (int i = 0; i < 4; i++) begin
          wr_i    = 1'b1;
          wdata_i = $urandom();
          #1;
          if (ready_o !== 1'b0) begin
            err_proto++;
            $display("ready_o was high while the engine owned the buffer in %s.", row.name);
          end
          next_cycle();
        end
        wr_i   = 1'b0;
        sess_i = 1'b0;
        finish_engine(row.name, exp);
        read_words({row.name, "_readback"}, row.base, 4);
      end
      default: ;
    endcase
  endtask

  // ==========================================================================
  // Test sequence
  // ==========================================================================

  initial begin
    void'($urandom(32'hcc4e87bb));
    rst        = 1'b1;
    sess_i     = 1'b0;
    wr_i       = 1'b0;
    rd_i       = 1'b0;
    base_i     = '0;
    addr_i     = '0;
    wdata_i    = '0;
    start_i    = 1'b0;
    eng_base_i = '0;
    count_i    = '0;
    act_i      = '0;
    wr_ptr     = '0;

    rows[0] = '{"burst_a",  OP_WRITE,     10'h010, 40, 32'h0000_0000};
    rows[1] = '{"read_a",   OP_READ,      10'h010, 40, 32'h0000_0000};
    rows[2] = '{"dot_a",    OP_RUN,       10'h010, 16, 32'h05fd_1280};
    rows[3] = '{"dot_full", OP_RUN,       10'h010, 40, 32'h7f80_01c3};
    rows[4] = '{"sess_run", OP_SESS_RUN,  10'h100, 8,  32'h8080_7f7f};
    rows[5] = '{"blocked",  OP_BLOCKED,   10'h010, 32, 32'h11ee_22dd};
    rows[6] = '{"neg_fill", OP_WRITE_NEG, 10'h200, 12, 32'h0000_0000};
    rows[7] = '{"read_neg", OP_READ,      10'h200, 12, 32'h0000_0000};
    rows[8] = '{"neg_run",  OP_RUN,       10'h200, 12, 32'h80ff_c381};
    rows[9] = '{"single",   OP_RUN,       10'h205, 1,  32'h7f80_02fe};

    // A host read costs three cycles a word, so four per counted word is enough.
    cycle_limit = 20;
    foreach (rows[r]) cycle_limit += 4 * rows[r].count + 40;

    repeat (10) @(posedge clk);
    #5 rst = 1'b0;
    next_cycle();

    foreach (rows[r]) apply_row(rows[r]);

    $display("Errors: %0d word, %0d accumulator, %0d protocol, %0d assertion",
             err_word, err_acc, err_proto, DUT.u_buffer.u_sva.fail_count);
    if (err_word + err_acc + err_proto + DUT.u_buffer.u_sva.fail_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+design
design/wbuf_pkg.sv
design/sram_bus_if.sv
design/weight_loader.sv
design/weight_sram.sv
design/weight_buffer.sv
design/dot_engine.sv
design/weight_subsys_top.sv
testbench/weight_subsys_sva.sv
testbench/weight_subsys_tb.sv
